// ==== vlog.f ====
+incdir+rtl
rtl/fu_pkg.sv
rtl/fu_operand_decode.sv
rtl/fu_alu_exec.sv
rtl/fu_mult_exec.sv
rtl/fu_result.sv
rtl/fu_top.sv
testbench/fu_tb.sv

// ==== testbench/fu_tb.sv ====
`include "fu_cfg.svh"

module fu_tb;
    import fu_pkg::*;

    localparam int PERIOD = 4;
    localparam int RESET_CYCLES = 8;
    localparam int N_RESET = 6; // idle cycles watched after reset
    localparam int N_ALU = 300;
    localparam int N_SEL = 300;
    localparam int N_BRANCH = 300;
    localparam int N_MULT = 200;
    localparam int N_STALL = 400;
    localparam int DRAIN_MAX = 64; // cycles allowed to empty the mult pipes
    localparam int QDEPTH = 16; // per lane expectation ring
    localparam int MARGIN = 100;
    localparam int TOTAL_CYCLES = RESET_CYCLES + N_RESET + N_ALU + N_SEL + N_BRANCH
                                + N_MULT + N_STALL + 2 * (DRAIN_MAX + `MULT_STAGES + 1);

    // expected multiplier result and the advancing edge count at issue
    typedef struct packed {
        data_t result;
        robn_t robn;
        prn_t dest_prn;
        logic [31:0] issue_adv;
    } mult_exp_t;

    logic clock;
    logic rst;
    fu_packet_t [`NUM_FU_ALU-1:0] alu_packets;
    fu_packet_t [`NUM_FU_MULT-1:0] mult_packets;
    logic [`NUM_FU_MULT-1:0] mult_avail;
    fu_state_t fu_state;
    fu_rob_packet_t [`NUM_FU_ALU-1:0] cond_rob_packets;

    integer seed;
    int errors;
    int checks;
    int tests;
    mult_exp_t exp_q [`NUM_FU_MULT][QDEPTH];
    int q_head [`NUM_FU_MULT];
    int q_count [`NUM_FU_MULT];
    logic [31:0] adv [`NUM_FU_MULT]; // advancing edges seen per lane
    logic stalled [`NUM_FU_MULT]; // avail was low at the last edge
    logic prev_done [`NUM_FU_MULT];
    fu_basic_t prev_res [`NUM_FU_MULT];

    fu_top i_dut (
        .clock            (clock),
        .rst              (rst),
        .alu_packets      (alu_packets),
        .mult_packets     (mult_packets),
        .mult_avail       (mult_avail),
        .fu_state         (fu_state),
        .cond_rob_packets (cond_rob_packets)
    );

    always #(PERIOD / 2) clock = ~clock;

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR at %0t: %s, expected %0h, got %0h", $time, what, expected, actual);
        end
    endtask

    function automatic data_t expect_opa(input fu_packet_t p);
        case (p.opa_sel)
            OPA_IS_RS1:  return p.op1;
            OPA_IS_PC:   return p.pc;
            OPA_IS_ZERO: return '0;
            default:     return `OPA_FILL;
        endcase
    endfunction

    function automatic data_t expect_opb(input fu_packet_t p);
        logic signed [11:0] i_imm;
        logic signed [11:0] s_imm;
        logic signed [12:0] b_imm;
        logic signed [20:0] j_imm;
        data_t v;
        i_imm = p.inst[31:20];
        s_imm = {p.inst[31:25], p.inst[11:7]};
        b_imm = {p.inst[31], p.inst[7], p.inst[30:25], p.inst[11:8], 1'b0};
        j_imm = {p.inst[31], p.inst[19:12], p.inst[20], p.inst[30:21], 1'b0};
        case (p.opb_sel)
            OPB_IS_RS2:   v = p.op2;
            OPB_IS_I_IMM: v = i_imm; // signed source sign extends
            OPB_IS_S_IMM: v = s_imm;
            OPB_IS_B_IMM: v = b_imm;
            OPB_IS_U_IMM: v = {p.inst[31:12], 12'h000};
            OPB_IS_J_IMM: v = j_imm;
            default:      v = `OPB_FILL;
        endcase
        return v;
    endfunction

    function automatic data_t expect_alu(input alu_func_e f, input data_t a, input data_t b);
        data_t r;
        case (f)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a - b;
            ALU_AND:  r = a & b;
            ALU_OR:   r = a | b;
            ALU_XOR:  r = a ^ b;
            ALU_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            ALU_SLL:  r = a << b[4:0];
            ALU_SRL:  r = a >> b[4:0];
            ALU_SRA:  r = $signed(a) >>> b[4:0];
            default:  r = `ALU_FILL;
        endcase
        return r;
    endfunction

    // rv32 conditional branch rule on rs1 and rs2
    function automatic logic branch_holds(input logic [2:0] f3, input data_t a, input data_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0; // 010 and 011 are not branches
        endcase
    endfunction

    function automatic data_t expect_product(input mult_func_e f, input data_t a, input data_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0] p;
        sa = $signed(a); // widened with sign
        sb = $signed(b);
        case (f)
            MULH:    p = sa * sb;
            MULHSU:  p = sa * $signed({32'b0, b});
            default: p = {32'b0, a} * {32'b0, b}; // mul and mulhu
        endcase
        return (f == MUL) ? p[31:0] : p[63:32];
    endfunction

    task automatic random_packet(output fu_packet_t p);
        logic [31:0] r;
        p = '0; // rs1 and rs2 selects, add, mul, no branch
        r = $random(seed);
        p.valid = r[0];
        p.dest_prn = r[8 +: `PRN_W];
        p.robn = r[16 +: `ROBN_W];
        p.inst = $random(seed);
        p.pc = $random(seed);
        p.op1 = $random(seed);
        p.op2 = $random(seed);
    endtask

    task automatic push_expect(input int l, input fu_packet_t p);
        mult_exp_t e;
        e.result = expect_product(p.mult_func, expect_opa(p), expect_opb(p));
        e.robn = p.robn;
        e.dest_prn = p.dest_prn;
        e.issue_adv = adv[l];
        exp_q[l][(q_head[l] + q_count[l]) % QDEPTH] = e;
        q_count[l]++;
    endtask

    function automatic int pending_results();
        int n;
        n = 0;
        for (int l = 0; l < `NUM_FU_MULT; l++) begin
            n += q_count[l];
        end
        return n;
    endfunction

    // registered mult outputs are sampled before the next drive
    task automatic check_mult_lanes();
        mult_exp_t e;
        logic done;
        fu_basic_t res;
        for (int l = 0; l < `NUM_FU_MULT; l++) begin
            done = fu_state.mult_prepared[l];
            res = fu_state.mult_packet[l];
            if (stalled[l]) begin
                check_value($sformatf("lane %0d held mult_prepared", l), prev_done[l], done);
                check_value($sformatf("lane %0d held mult_packet", l), prev_res[l], res);
            end else if (done) begin
                if (q_count[l] == 0) begin
                    errors++;
                    $display("ERROR at %0t: lane %0d gave a result never issued", $time, l);
                end else begin
                    e = exp_q[l][q_head[l]]; // oldest entry first
                    q_head[l] = (q_head[l] + 1) % QDEPTH;
                    q_count[l]--;
                    check_value($sformatf("lane %0d product", l), e.result, res.result);
                    check_value($sformatf("lane %0d robn", l), e.robn, res.robn);
                    check_value($sformatf("lane %0d dest_prn", l), e.dest_prn, res.dest_prn);
                    check_value($sformatf("lane %0d latency", l), `MULT_STAGES,
                                adv[l] - e.issue_adv);
                end
            end else if (q_count[l] != 0 &&
                         adv[l] - exp_q[l][q_head[l]].issue_adv >= `MULT_STAGES) begin
                errors++;
                $display("ERROR at %0t: lane %0d result overdue", $time, l);
            end
            prev_done[l] = done;
            prev_res[l] = res;
        end
    endtask

    // advances one clock and counts edges where avail was high
    task automatic step();
        @(posedge clock);
        for (int l = 0; l < `NUM_FU_MULT; l++) begin
            stalled[l] = !mult_avail[l];
            if (mult_avail[l]) begin
                adv[l]++;
            end
        end
        #1;
        check_mult_lanes();
    endtask

    task automatic check_alu_lanes();
        fu_packet_t p;
        data_t res;
        data_t target;
        logic taken;
        for (int a = 0; a < `NUM_FU_ALU; a++) begin
            p = alu_packets[a];
            res = expect_alu(p.alu_func, expect_opa(p), expect_opb(p));
            taken = p.uncond_branch | (p.cond_branch & branch_holds(p.inst[14:12], p.op1, p.op2));
            target = res;
            if (p.uncond_branch) begin
                target[0] = 1'b0; // jalr alignment
            end
            check_value($sformatf("alu %0d prepared", a), p.valid, fu_state.alu_prepared[a]);
            check_value($sformatf("alu %0d executed", a), p.valid & p.cond_branch,
                        cond_rob_packets[a].executed);
            if (p.valid) begin
                check_value($sformatf("alu %0d result", a), res,
                            fu_state.alu_packet[a].basic.result);
                check_value($sformatf("alu %0d robn", a), p.robn,
                            fu_state.alu_packet[a].basic.robn);
                check_value($sformatf("alu %0d dest_prn", a), p.dest_prn,
                            fu_state.alu_packet[a].basic.dest_prn);
                check_value($sformatf("alu %0d pc", a), p.pc, fu_state.alu_packet[a].pc);
                check_value($sformatf("alu %0d take_branch", a), taken,
                            fu_state.alu_packet[a].take_branch);
                check_value($sformatf("alu %0d cond_branch", a), p.cond_branch,
                            fu_state.alu_packet[a].cond_branch);
                check_value($sformatf("alu %0d uncond_branch", a), p.uncond_branch,
                            fu_state.alu_packet[a].uncond_branch);
                check_value($sformatf("rob %0d taken", a), taken, cond_rob_packets[a].branch_taken);
                check_value($sformatf("rob %0d robn", a), p.robn, cond_rob_packets[a].robn);
                check_value($sformatf("rob %0d target", a), target,
                            cond_rob_packets[a].target_addr);
            end
        end
    endtask

    task automatic idle_mult();
        for (int l = 0; l < `NUM_FU_MULT; l++) begin
            mult_packets[l] = '0;
        end
        mult_avail = '1;
    endtask

    // lets the pipes empty and then watches for spurious results
    task automatic drain_mult();
        int n;
        n = 0;
        while (pending_results() != 0 && n < DRAIN_MAX) begin
            step();
            idle_mult();
            n++;
        end
        if (pending_results() != 0) begin
            errors++;
            $display("ERROR at %0t: %0d mult results never came out", $time, pending_results());
        end
        repeat (`MULT_STAGES + 1) begin
            step();
            idle_mult();
        end
    endtask

    task automatic test_done(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d mismatches", name, errors - err_before);
        end
    endtask

    initial begin
        fu_packet_t p;
        logic [31:0] r;
        int err0;
        seed = 32'h70e2_18f9;
        errors = 0;
        checks = 0;
        tests = 0;
        clock = 1'b0;
        rst = 1'b1;
        alu_packets = '0;
        mult_packets = '0;
        mult_avail = '1;
        for (int l = 0; l < `NUM_FU_MULT; l++) begin
            q_head[l] = 0;
            q_count[l] = 0;
            adv[l] = '0;
            stalled[l] = 1'b0;
            prev_done[l] = 1'b0;
            prev_res[l] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clock);
        #1 rst = 1'b0;

        // pipes empty and quiet after reset
        err0 = errors;
        check_value("mult_prepared after reset", '0, fu_state.mult_prepared);
        for (int i = 0; i < N_RESET; i++) begin
            step();
            check_value("mult_prepared idle", '0, fu_state.mult_prepared);
            for (int l = 0; l < `NUM_FU_MULT; l++) begin
                check_value($sformatf("lane %0d mult_packet idle", l), '0,
                            fu_state.mult_packet[l]);
            end
        end
        test_done("reset", err0);

        // register ops with an opcode walk that hits every func
        err0 = errors;
        for (int i = 0; i < N_ALU; i++) begin
            step();
            for (int a = 0; a < `NUM_FU_ALU; a++) begin
                random_packet(p);
                p.alu_func = alu_func_e'((i * `NUM_FU_ALU + a) % 10);
                alu_packets[a] = p;
            end
            #1;
            check_alu_lanes();
        end
        test_done("alu_reg", err0);

        // random selects incl. undefined ones
        err0 = errors;
        for (int i = 0; i < N_SEL; i++) begin
            step();
            for (int a = 0; a < `NUM_FU_ALU; a++) begin
                random_packet(p);
                r = $random(seed);
                p.opa_sel = opa_sel_e'(r[1:0]);
                p.opb_sel = opb_sel_e'(r[4:2]);
                p.alu_func = alu_func_e'(r[31:8] % 10);
                alu_packets[a] = p;
            end
            #1;
            check_alu_lanes();
        end
        test_done("operand_sel", err0);

        // cond branch pc+b_imm, jalr rs1+i_imm, jal pc+j_imm
        err0 = errors;
        for (int i = 0; i < N_BRANCH; i++) begin
            step();
            for (int a = 0; a < `NUM_FU_ALU; a++) begin
                random_packet(p);
                r = $random(seed);
                if (r[1] == 1'b0) begin
                    p.cond_branch = 1'b1;
                    p.opa_sel = OPA_IS_PC;
                    p.opb_sel = OPB_IS_B_IMM;
                    if (r[3:2] == 2'b00) begin
                        p.op2 = p.op1; // hit the equal case often
                    end
                end else if (r[0]) begin
                    p.uncond_branch = 1'b1;
                    p.opb_sel = OPB_IS_I_IMM;
                end else begin
                    p.uncond_branch = 1'b1;
                    p.opa_sel = OPA_IS_PC;
                    p.opb_sel = OPB_IS_J_IMM;
                end
                alu_packets[a] = p;
            end
            #1;
            check_alu_lanes();
        end
        alu_packets = '0;
        test_done("branch", err0);

        // back to back issue with avail always high
        err0 = errors;
        for (int i = 0; i < N_MULT; i++) begin
            step();
            mult_avail = '1;
            for (int l = 0; l < `NUM_FU_MULT; l++) begin
                random_packet(p);
                p.valid = 1'b1;
                p.mult_func = mult_func_e'((i + l) % 4);
                mult_packets[l] = p;
                push_expect(l, p);
            end
        end
        drain_mult();
        test_done("mult", err0);

        // random stalls with no issue into a stalled lane
        err0 = errors;
        for (int i = 0; i < N_STALL; i++) begin
            step();
            for (int l = 0; l < `NUM_FU_MULT; l++) begin
                random_packet(p);
                r = $random(seed);
                p.mult_func = mult_func_e'(r[5:4]);
                mult_avail[l] = (r[2:0] >= 3'd3); // high about 5 in 8
                p.valid = mult_avail[l] & r[3];
                mult_packets[l] = p;
                if (p.valid) begin
                    push_expect(l, p);
                end
            end
        end
        drain_mult();
        test_done("stall", err0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // bound on the whole run
    initial begin
        #((TOTAL_CYCLES + MARGIN) * PERIOD);
        $display("run timed out after %0d cycles, tests did not finish",
                 TOTAL_CYCLES + MARGIN);
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== rtl/fu_top.sv ====
`include "fu_cfg.svh"

module fu_top (
    input  logic                                        clock,
    input  logic                                        rst,
    input  fu_pkg::fu_packet_t [`NUM_FU_ALU-1:0]        alu_packets,
    input  fu_pkg::fu_packet_t [`NUM_FU_MULT-1:0]       mult_packets,
    input  logic [`NUM_FU_MULT-1:0]                     mult_avail, // from the selector
    output fu_pkg::fu_state_t                           fu_state,
    output fu_pkg::fu_rob_packet_t [`NUM_FU_ALU-1:0]    cond_rob_packets
);
    import fu_pkg::*;

    logic [`NUM_FU_ALU-1:0] alu_prepared;
    fu_alu_state_t [`NUM_FU_ALU-1:0] alu_states;
    logic [`NUM_FU_MULT-1:0] mult_done;
    fu_basic_t [`NUM_FU_MULT-1:0] mult_results;

    // alu lanes, decode then execute in the same cycle
    for (genvar a = 0; a < `NUM_FU_ALU; a++) begin : g_alu_lane
        data_t opa;
        data_t opb;

        fu_operand_decode i_dec (
            .pkt (alu_packets[a]),
            .opa (opa),
            .opb (opb)
        );

        fu_alu_exec i_alu (
            .pkt      (alu_packets[a]),
            .opa      (opa),
            .opb      (opb),
            .prepared (alu_prepared[a]),
            .state    (alu_states[a])
        );
    end

    // mult lanes, same decode feeding the pipelined multiplier
    for (genvar m = 0; m < `NUM_FU_MULT; m++) begin : g_mult_lane
        data_t opa;
        data_t opb;

        fu_operand_decode i_dec (
            .pkt (mult_packets[m]),
            .opa (opa),
            .opb (opb)
        );

        fu_mult_exec i_mult (
            .clock    (clock),
            .rst      (rst),
            .start    (mult_packets[m].valid),
            .avail    (mult_avail[m]),
            .opa      (opa),
            .opb      (opb),
            .func     (mult_packets[m].mult_func),
            .robn     (mult_packets[m].robn),
            .dest_prn (mult_packets[m].dest_prn),
            .done     (mult_done[m]),
            .result   (mult_results[m])
        );
    end

    fu_result i_result (
        .alu_prepared     (alu_prepared),
        .alu_states       (alu_states),
        .mult_done        (mult_done),
        .mult_results     (mult_results),
        .fu_state         (fu_state),
        .cond_rob_packets (cond_rob_packets)
    );

endmodule

// ==== rtl/fu_result.sv ====
`include "fu_cfg.svh"

module fu_result (
    input  logic [`NUM_FU_ALU-1:0]                          alu_prepared,
    input  fu_pkg::fu_alu_state_t [`NUM_FU_ALU-1:0]         alu_states,
    input  logic [`NUM_FU_MULT-1:0]                         mult_done,
    input  fu_pkg::fu_basic_t [`NUM_FU_MULT-1:0]            mult_results,
    output fu_pkg::fu_state_t                               fu_state,
    output fu_pkg::fu_rob_packet_t [`NUM_FU_ALU-1:0]        cond_rob_packets
);
    import fu_pkg::*;

    data_t [`NUM_FU_ALU-1:0] lsb_mask; // clears bit 0 for jalr

    // cluster state seen by the rob and the cdb side
    always_comb begin
        fu_state.alu_prepared = alu_prepared;
        fu_state.alu_packet = alu_states;
        fu_state.mult_prepared = mult_done;
        fu_state.mult_packet = mult_results;
    end

    always_comb begin
        for (int i = 0; i < `NUM_FU_ALU; i++) begin
            lsb_mask[i] = ~{{(`XLEN-1){1'b0}}, alu_states[i].uncond_branch};
            cond_rob_packets[i].robn = alu_states[i].basic.robn;
            // only conditional branches report here
            cond_rob_packets[i].executed = alu_prepared[i] & alu_states[i].cond_branch;
            cond_rob_packets[i].branch_taken = alu_states[i].take_branch;
            cond_rob_packets[i].target_addr = alu_states[i].basic.result & lsb_mask[i];
        end
    end

endmodule

// ==== rtl/fu_mult_exec.sv ====
`include "fu_cfg.svh"

module fu_mult_exec (
    input  logic               clock,
    input  logic               rst,
    input  logic               start,
    input  logic               avail,
    input  fu_pkg::data_t      opa,
    input  fu_pkg::data_t      opb,
    input  fu_pkg::mult_func_e func,
    input  fu_pkg::robn_t      robn,
    input  fu_pkg::prn_t       dest_prn,
    output logic               done,
    output fu_pkg::fu_basic_t  result
);
    import fu_pkg::*;

    // multiplier bits consumed per stage
    localparam int SLICE_W = PROD_W / `MULT_STAGES;

    logic opa_signed;
    logic opb_signed;
    prod_t mcand_in;
    prod_t mplier_in;
    mult_stage_t stg_d [`MULT_STAGES];
    mult_stage_t stg_q [`MULT_STAGES];
    mult_stage_t last;

    // mulhsu treats only rs1 as signed, mul does not care
    assign opa_signed = (func == MULH) || (func == MULHSU);
    assign opb_signed = (func == MULH);
    assign mcand_in = {{`XLEN{opa_signed & opa[`XLEN-1]}}, opa};
    assign mplier_in = {{`XLEN{opb_signed & opb[`XLEN-1]}}, opb};

    always_comb begin
        // first stage takes the issued packet
        stg_d[0].valid = start;
        stg_d[0].func = func;
        stg_d[0].robn = robn;
        stg_d[0].dest_prn = dest_prn;
        stg_d[0].prod = mcand_in * mplier_in[SLICE_W-1:0];
        stg_d[0].mcand = mcand_in << SLICE_W;
        stg_d[0].mplier = mplier_in >> SLICE_W;

        // later stages add one more partial product each
        for (int i = 1; i < `MULT_STAGES; i++) begin
            stg_d[i] = stg_q[i-1]; // tags ride along
            stg_d[i].prod = stg_q[i-1].prod
                          + stg_q[i-1].mcand * stg_q[i-1].mplier[SLICE_W-1:0];
            stg_d[i].mcand = stg_q[i-1].mcand << SLICE_W;
            stg_d[i].mplier = stg_q[i-1].mplier >> SLICE_W;
        end
    end

    // whole pipe freezes while avail is low
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `MULT_STAGES; i++) begin
                stg_q[i] <= '0;
            end
        end else if (avail) begin
            stg_q <= stg_d;
        end
    end

    assign last = stg_q[`MULT_STAGES-1];
    assign done = last.valid;

    always_comb begin
        result.robn = last.robn;
        result.dest_prn = last.dest_prn;
        if (last.func == MUL) begin
            result.result = last.prod[`XLEN-1:0];
        end else begin
            result.result = last.prod[PROD_W-1:`XLEN]; // high word variants
        end
    end

endmodule

// ==== rtl/fu_alu_exec.sv ====
`include "fu_cfg.svh"

module fu_alu_exec (
    input  fu_pkg::fu_packet_t    pkt,
    input  fu_pkg::data_t         opa,
    input  fu_pkg::data_t         opb,
    output logic                  prepared,
    output fu_pkg::fu_alu_state_t state
);
    import fu_pkg::*;

    logic signed [`XLEN-1:0] sa; // signed views of the operands
    logic signed [`XLEN-1:0] sb;
    logic signed [`XLEN-1:0] s_rs1; // signed views for the compare
    logic signed [`XLEN-1:0] s_rs2;
    logic [4:0] shamt;
    logic [2:0] funct3;
    logic cmp_take;
    data_t alu_out;

    assign sa = opa;
    assign sb = opb;
    assign s_rs1 = pkt.op1;
    assign s_rs2 = pkt.op2;
    assign shamt = opb[4:0]; // rv32 shifts use 5 bits
    assign funct3 = pkt.inst[14:12];

    always_comb begin
        case (pkt.alu_func)
            ALU_ADD:  alu_out = opa + opb;
            ALU_SUB:  alu_out = opa - opb;
            ALU_AND:  alu_out = opa & opb;
            ALU_OR:   alu_out = opa | opb;
            ALU_XOR:  alu_out = opa ^ opb;
            ALU_SLT:  alu_out = {{(`XLEN-1){1'b0}}, sa < sb};
            ALU_SLTU: alu_out = {{(`XLEN-1){1'b0}}, opa < opb};
            ALU_SLL:  alu_out = opa << shamt;
            ALU_SRL:  alu_out = opa >> shamt;
            ALU_SRA:  alu_out = sa >>> shamt; // keeps sign
            default:  alu_out = `ALU_FILL;
        endcase
    end

    // branch condition, compares rs values and not the muxed operands
    always_comb begin
        case (funct3)
            3'b000:  cmp_take = pkt.op1 == pkt.op2; // beq
            3'b001:  cmp_take = pkt.op1 != pkt.op2; // bne
            3'b100:  cmp_take = s_rs1 < s_rs2; // blt
            3'b101:  cmp_take = s_rs1 >= s_rs2; // bge
            3'b110:  cmp_take = pkt.op1 < pkt.op2; // bltu
            3'b111:  cmp_take = pkt.op1 >= pkt.op2; // bgeu
            default: cmp_take = 1'b0;
        endcase
    end

    assign prepared = pkt.valid; // single cycle, done when issued

    always_comb begin
        state.basic.robn = pkt.robn;
        state.basic.dest_prn = pkt.dest_prn;
        state.basic.result = alu_out; // also the branch target
        state.take_branch = pkt.uncond_branch | (pkt.cond_branch & cmp_take);
        state.cond_branch = pkt.cond_branch;
        state.uncond_branch = pkt.uncond_branch;
        state.pc = pkt.pc;
    end

endmodule

// ==== rtl/fu_operand_decode.sv ====
`include "fu_cfg.svh"

module fu_operand_decode (
    input  fu_pkg::fu_packet_t pkt,
    output fu_pkg::data_t      opa,
    output fu_pkg::data_t      opb
);
    import fu_pkg::*;

    inst_t inst;
    data_t i_imm; // loads, op-imm, jalr
    data_t s_imm; // stores
    data_t b_imm; // cond branches
    data_t u_imm; // lui, auipc
    data_t j_imm; // jal

    assign inst = pkt.inst;

    // immediates, all sign extended from bit 31
    assign i_imm = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    assign s_imm = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign b_imm = {
        {(`XLEN-13){inst[31]}},
        inst[31],
        inst[7],
        inst[30:25],
        inst[11:8],
        1'b0 // halfword aligned
    };
    assign u_imm = {inst[31:12], 12'b0};
    assign j_imm = {
        {(`XLEN-21){inst[31]}},
        inst[31],
        inst[19:12],
        inst[20],
        inst[30:21],
        1'b0
    };

    // operand a mux
    always_comb begin
        case (pkt.opa_sel)
            OPA_IS_RS1:  opa = pkt.op1;
            OPA_IS_PC:   opa = pkt.pc; // auipc, jal
            OPA_IS_ZERO: opa = '0; // lui
            default:     opa = `OPA_FILL;
        endcase
    end

    // operand b mux
    always_comb begin
        case (pkt.opb_sel)
            OPB_IS_RS2:   opb = pkt.op2;
            OPB_IS_I_IMM: opb = i_imm;
            OPB_IS_S_IMM: opb = s_imm;
            OPB_IS_B_IMM: opb = b_imm;
            OPB_IS_U_IMM: opb = u_imm;
            OPB_IS_J_IMM: opb = j_imm;
            default:      opb = `OPB_FILL; // encodings 6, 7
        endcase
    end

endmodule

// ==== rtl/fu_pkg.sv ====
`include "fu_cfg.svh"

package fu_pkg;

    localparam int PROD_W = 2 * `XLEN; // full product width

    typedef logic [`XLEN-1:0] data_t;
    typedef logic [31:0] inst_t; // raw rv32 instruction word
    typedef logic [`PRN_W-1:0] prn_t;
    typedef logic [`ROBN_W-1:0] robn_t;
    typedef logic [PROD_W-1:0] prod_t;

    // alu opcodes, 10..15 unused
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL = 4'd7,
        ALU_SRL = 4'd8,
        ALU_SRA = 4'd9
    } alu_func_e;

    // rv32m multiply flavours
    typedef enum logic [1:0] {
        MUL = 2'd0, // low word
        MULH = 2'd1, // signed x signed, high
        MULHSU = 2'd2, // signed x unsigned, high
        MULHU = 2'd3 // unsigned x unsigned, high
    } mult_func_e;

    typedef enum logic [1:0] {
        OPA_IS_RS1 = 2'd0,
        OPA_IS_PC = 2'd1,
        OPA_IS_ZERO = 2'd2
    } opa_sel_e;

    typedef enum logic [2:0] {
        OPB_IS_RS2 = 3'd0,
        OPB_IS_I_IMM = 3'd1,
        OPB_IS_S_IMM = 3'd2,
        OPB_IS_B_IMM = 3'd3,
        OPB_IS_U_IMM = 3'd4,
        OPB_IS_J_IMM = 3'd5
    } opb_sel_e;

    // issued packet from the reservation stations
    typedef struct packed {
        logic valid;
        inst_t inst;
        data_t pc;
        alu_func_e alu_func;
        mult_func_e mult_func;
        data_t op1;
        data_t op2;
        prn_t dest_prn;
        robn_t robn;
        opa_sel_e opa_sel;
        opb_sel_e opb_sel;
        logic cond_branch;
        logic uncond_branch;
    } fu_packet_t;

    typedef struct packed {
        robn_t robn;
        prn_t dest_prn;
        data_t result;
    } fu_basic_t;

    typedef struct packed {
        fu_basic_t basic;
        logic take_branch;
        logic cond_branch;
        logic uncond_branch;
        data_t pc;
    } fu_alu_state_t;

    // branch outcome toward the rob
    typedef struct packed {
        robn_t robn;
        logic executed;
        logic branch_taken;
        data_t target_addr;
    } fu_rob_packet_t;

    typedef struct packed {
        logic [`NUM_FU_ALU-1:0] alu_prepared;
        fu_alu_state_t [`NUM_FU_ALU-1:0] alu_packet;
        logic [`NUM_FU_MULT-1:0] mult_prepared;
        fu_basic_t [`NUM_FU_MULT-1:0] mult_packet;
    } fu_state_t;

    // one multiplier pipe register
    typedef struct packed {
        logic valid;
        mult_func_e func;
        robn_t robn;
        prn_t dest_prn;
        prod_t mcand; // shifted multiplicand
        prod_t mplier; // remaining multiplier bits
        prod_t prod; // partial sum so far
    } mult_stage_t;

endpackage

// ==== rtl/fu_cfg.svh ====
`ifndef FU_CFG_SVH
`define FU_CFG_SVH

// lane counts for the cluster
`define NUM_FU_ALU 2 // single-cycle alu lanes
`define NUM_FU_MULT 2 // pipelined mult lanes

// multiplier pipe depth, must divide 2*XLEN evenly
`define MULT_STAGES 4

// datapath widths
`define XLEN 32 // rv32 word
`define PRN_W 6 // physical reg tag
`define ROBN_W 5 // rob index

// fill patterns for undefined selects and opcodes
// easy to spot in a waveform
`define OPA_FILL 32'hdead_face
`define OPB_FILL 32'hface_feed
`define ALU_FILL 32'hface_beec

`endif
